//--- list.f
+incdir+src
src/vec_pkg.sv
src/vec_color_delay.sv
src/vec_xy_scale.sv
src/vec_point_filter.sv
src/vec_point_fifo.sv
src/vec_adc_xy.sv
verif/tb_vec_adc_xy.sv

//--- run.sh
#!/bin/sh
# build and run the point capture testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_vec_adc_xy -o tb_vec_adc_xy > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_vec_adc_xy > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

//--- src/vec_adc_xy.sv
`timescale 1ns/100ps
`default_nettype none

`include "vec_macros.svh"

// beam position capture for the vector display
module vec_adc_xy (
  input  logic                       adc_clk,
  input  logic                       rst_n,
  input  logic [`VEC_DATA_WIDTH-1:0] adc_x,
  input  logic [`VEC_DATA_WIDTH-1:0] adc_y,
  input  logic                       red,
  input  logic                       grn,
  input  logic                       blu,
  input  vec_pkg::orient_t           orient,
  input  logic                       point_ready,
  output logic                       point_valid,
  output logic                       overflow,
  output logic [`VEC_DATA_WIDTH-1:0] point_x,
  output logic [`VEC_DATA_WIDTH-1:0] point_y,
  output logic                       point_red,
  output logic                       point_grn,
  output logic                       point_blu
);

  // colour after the converter plus scaler delay
  logic [2:0] color_d;

  // scaler outputs
  logic [`VEC_DATA_WIDTH-1:0] scaled_x;
  logic [`VEC_DATA_WIDTH-1:0] scaled_y;

  // filter to fifo
  logic            wr_en;
  vec_pkg::point_t wr_point;

  // fifo head
  vec_pkg::point_t rd_point;

  // colour bits wait for the position
  vec_color_delay #(
    .cycles(`VEC_COLOR_DELAY)
  ) i_color_delay (
    .adc_clk  (adc_clk),
    .rst_n    (rst_n),
    .color_in ({red, grn, blu}),
    .color_out(color_d)
  );

  vec_xy_scale i_xy_scale (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .adc_x   (adc_x),
    .adc_y   (adc_y),
    .orient  (orient),
    .scaled_x(scaled_x),
    .scaled_y(scaled_y)
  );

  vec_point_filter i_point_filter (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .scaled_x(scaled_x),
    .scaled_y(scaled_y),
    .color   (color_d),
    .wr_en   (wr_en),
    .wr_point(wr_point)
  );

  vec_point_fifo i_point_fifo (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_point   (wr_point),
    .point_ready(point_ready),
    .point_valid(point_valid),
    .rd_point   (rd_point),
    .overflow   (overflow)
  );

  // head word onto the loose ports
  assign point_x   = rd_point.x;
  assign point_y   = rd_point.y;
  assign point_red = rd_point.red;
  assign point_grn = rd_point.grn;
  assign point_blu = rd_point.blu;

endmodule

`default_nettype wire

//--- src/vec_color_delay.sv
`timescale 1ns/100ps
`default_nettype none

// lines the beam enables up with the converted position
module vec_color_delay #(
  parameter int cycles = 9
) (
  input  logic       adc_clk,
  input  logic       rst_n,
  input  logic [2:0] color_in,
  output logic [2:0] color_out
);

  // one entry per cycle of delay
  logic [2:0] stage [cycles];

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      // beam off through the whole chain after reset
      for (int i = 0; i < cycles; i++) begin
        stage[i] <= 3'b000;
      end
    end else begin
      stage[0] <= color_in;
      // shift towards the output end
      for (int i = 1; i < cycles; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // oldest entry
  assign color_out = stage[cycles-1];

endmodule

`default_nettype wire

//--- src/vec_macros.svh
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// width of one converter sample and of a scaled coordinate
`define VEC_DATA_WIDTH 10

// x axis scale fraction
`define VEC_SCALE_NUM_X 5
`define VEC_SCALE_DEN_X 8

// y axis scale fraction
`define VEC_SCALE_NUM_Y 15
`define VEC_SCALE_DEN_Y 32

// product width, holds full scale sample times the larger numerator
`define VEC_SCALE_BITS 14

// converter latency in adc_clk cycles
`define VEC_ADC_DELAY 7

// colour must also ride through the two scaling stages
`define VEC_COLOR_DELAY (`VEC_ADC_DELAY + 2)

// point fifo address width, 16 entries
`define VEC_FIFO_AW 4

`endif

//--- src/vec_pkg.sv
`default_nettype none

`include "vec_macros.svh"

package vec_pkg;

  // orientation opcodes
  // mirror x is the reset default of the display path
  typedef enum logic [1:0] {
    ORIENT_MIRROR_X = 2'd0,
    ORIENT_NORMAL   = 2'd1,
    ORIENT_MIRROR_Y = 2'd2,
    ORIENT_SWAP_XY  = 2'd3
  } orient_t;

  // one captured point as stored in the fifo
  // x in the top bits, blue in bit 0
  typedef struct packed {
    logic [`VEC_DATA_WIDTH-1:0] x;
    logic [`VEC_DATA_WIDTH-1:0] y;
    logic                       red;
    logic                       grn;
    logic                       blu;
  } point_t;

endpackage

`default_nettype wire

//--- src/vec_point_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "vec_macros.svh"

// single clock fwft fifo for captured points
// read side uses valid/ready and the write side cannot stall
module vec_point_fifo (
  input  logic            adc_clk,
  input  logic            rst_n,
  input  logic            wr_en,
  input  vec_pkg::point_t wr_point,
  input  logic            point_ready,
  output logic            point_valid,
  output vec_pkg::point_t rd_point,
  output logic            overflow
);

  localparam int depth = 1 << `VEC_FIFO_AW;

  // point storage
  vec_pkg::point_t mem [depth];

  // pointers carry one extra wrap bit
  logic [`VEC_FIFO_AW:0] wr_ptr;
  logic [`VEC_FIFO_AW:0] rd_ptr;

  logic empty;
  logic full;
  logic do_read;
  logic do_write;

  // equal pointers mean empty
  assign empty = (wr_ptr == rd_ptr);

  // same slot but wrap bits differ means full
  assign full = (wr_ptr[`VEC_FIFO_AW] != rd_ptr[`VEC_FIFO_AW]) &&
                (wr_ptr[`VEC_FIFO_AW-1:0] == rd_ptr[`VEC_FIFO_AW-1:0]);

  // a word leaves on every valid and ready edge
  assign do_read = point_valid && point_ready;

  // full is fine when a read frees the slot in the same cycle
  assign do_write = wr_en && (!full || do_read);

  // write port
  always_ff @(posedge adc_clk) begin
    if (do_write) begin
      mem[wr_ptr[`VEC_FIFO_AW-1:0]] <= wr_point;
    end
  end

  // pointer update
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // sticky drop flag that only reset clears
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (wr_en && !do_write) begin
      overflow <= 1'b1;
    end
  end

  // head word falls through to the output
  assign point_valid = !empty;
  assign rd_point    = mem[rd_ptr[`VEC_FIFO_AW-1:0]];

endmodule

`default_nettype wire

//--- src/vec_point_filter.sv
`timescale 1ns/100ps
`default_nettype none

`include "vec_macros.svh"

// passes lit points that differ from the previous sample
module vec_point_filter (
  input  logic                       adc_clk,
  input  logic                       rst_n,
  input  logic [`VEC_DATA_WIDTH-1:0] scaled_x,
  input  logic [`VEC_DATA_WIDTH-1:0] scaled_y,
  input  logic [2:0]                 color,
  output logic                       wr_en,
  output vec_pkg::point_t            wr_point
);

  // candidate built from this cycle's position and colour
  vec_pkg::point_t cand;

  // last candidate seen, lit or not
  vec_pkg::point_t prev;

  logic lit;
  logic changed;

  // colour arrives as {red, grn, blu}
  assign cand.x   = scaled_x;
  assign cand.y   = scaled_y;
  assign cand.red = color[2];
  assign cand.grn = color[1];
  assign cand.blu = color[0];

  // any gun on
  assign lit = |color;

  // any field differs, colour included
  assign changed = (cand != prev);

  assign wr_en    = lit && changed;
  assign wr_point = cand;

  // all zero after reset, an unlit word never matches a lit one
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      prev <= '0;
    end else begin
      prev <= cand;
    end
  end

endmodule

`default_nettype wire

//--- src/vec_xy_scale.sv
`timescale 1ns/100ps
`default_nettype none

`include "vec_macros.svh"

// orientation then fixed fractional scaling, two register stages
module vec_xy_scale (
  input  logic                       adc_clk,
  input  logic                       rst_n,
  input  logic [`VEC_DATA_WIDTH-1:0] adc_x,
  input  logic [`VEC_DATA_WIDTH-1:0] adc_y,
  input  vec_pkg::orient_t           orient,
  output logic [`VEC_DATA_WIDTH-1:0] scaled_x,
  output logic [`VEC_DATA_WIDTH-1:0] scaled_y
);

  // full scale sample, used for mirroring
  localparam logic [`VEC_DATA_WIDTH-1:0] max_adc = {`VEC_DATA_WIDTH{1'b1}};

  // oriented sources before the multiply
  logic [`VEC_DATA_WIDTH-1:0] src_x;
  logic [`VEC_DATA_WIDTH-1:0] src_y;

  // stage one products
  logic [`VEC_SCALE_BITS-1:0] prod_x;
  logic [`VEC_SCALE_BITS-1:0] prod_y;

  // pick and mirror the axes
  always_comb begin
    case (orient)
      vec_pkg::ORIENT_NORMAL: begin
        src_x = adc_x;
        src_y = adc_y;
      end
      vec_pkg::ORIENT_MIRROR_Y: begin
        src_x = adc_x;
        src_y = max_adc - adc_y;
      end
      vec_pkg::ORIENT_SWAP_XY: begin
        // axes exchanged, no mirroring
        src_x = adc_y;
        src_y = adc_x;
      end
      default: begin
        // ORIENT_MIRROR_X
        src_x = max_adc - adc_x;
        src_y = adc_y;
      end
    endcase
  end

  // stage one, multiply by the numerators at full width
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      prod_x <= '0;
      prod_y <= '0;
    end else begin
      prod_x <= `VEC_SCALE_BITS'(src_x) * `VEC_SCALE_NUM_X;
      prod_y <= `VEC_SCALE_BITS'(src_y) * `VEC_SCALE_NUM_Y;
    end
  end

  // stage two, divide by the power of two denominators
  // only the low coordinate bits are kept
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      scaled_x <= '0;
      scaled_y <= '0;
    end else begin
      scaled_x <= `VEC_DATA_WIDTH'(prod_x / `VEC_SCALE_DEN_X);
      scaled_y <= `VEC_DATA_WIDTH'(prod_y / `VEC_SCALE_DEN_Y);
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_vec_adc_xy.sv
`timescale 1ns/100ps
`default_nettype none

`include "vec_macros.svh"

module tb_vec_adc_xy;

  logic                       adc_clk;
  logic                       rst_n;
  logic                       point_ready;
  logic                       red;
  logic                       grn;
  logic                       blu;
  logic [`VEC_DATA_WIDTH-1:0] adc_x;
  logic [`VEC_DATA_WIDTH-1:0] adc_y;
  logic [`VEC_DATA_WIDTH-1:0] point_x;
  logic [`VEC_DATA_WIDTH-1:0] point_y;
  logic                       point_valid;
  logic                       overflow;
  logic                       point_red;
  logic                       point_grn;
  logic                       point_blu;
  vec_pkg::orient_t           orient;

  // colour history and last candidate of the reference model
  vec_pkg::point_t  exp_q [$];
  vec_pkg::point_t  prev_cand;
  logic [2:0]       col_hist [`VEC_ADC_DELAY];
  vec_pkg::orient_t mode;
  logic             ready_sel;
  int               last_x;
  int               last_y;

  integer seed;
  int     err_cnt;
  int     out_cnt;
  int     test_err;
  int     test_out;
  int     pass_cnt;
  int     fail_cnt;
  logic   timeout_hit;

  vec_adc_xy i_dut (.*);

  always #10 adc_clk = ~adc_clk;

  // expected point from the orientation and scale rules
  function automatic vec_pkg::point_t model_point(input int ax, input int ay,
                                                  input vec_pkg::orient_t o,
                                                  input logic [2:0] c);
    vec_pkg::point_t p;
    int full;
    int ox;
    int oy;
    full = (1 << `VEC_DATA_WIDTH) - 1;
    ox = (o == vec_pkg::ORIENT_MIRROR_X) ? full - ax : ax;
    oy = (o == vec_pkg::ORIENT_MIRROR_Y) ? full - ay : ay;
    if (o == vec_pkg::ORIENT_SWAP_XY) begin
      ox = ay;
      oy = ax;
    end
    p.x = `VEC_DATA_WIDTH'(ox * `VEC_SCALE_NUM_X / `VEC_SCALE_DEN_X);
    p.y = `VEC_DATA_WIDTH'(oy * `VEC_SCALE_NUM_Y / `VEC_SCALE_DEN_Y);
    {p.red, p.grn, p.blu} = c;
    return p;
  endfunction

  // one sample per clock with the model following along
  task automatic drive(input int dx, input int dy, input logic [2:0] dc);
    vec_pkg::point_t cand;
    @(posedge adc_clk);
    adc_x           <= `VEC_DATA_WIDTH'(dx);
    adc_y           <= `VEC_DATA_WIDTH'(dy);
    {red, grn, blu} <= dc;
    orient          <= mode;
    point_ready     <= ready_sel;
    // position meets the colour driven VEC_ADC_DELAY samples back
    cand = model_point(dx, dy, mode, col_hist[`VEC_ADC_DELAY-1]);
    if ((cand.red || cand.grn || cand.blu) && cand != prev_cand) begin
      exp_q.push_back(cand);
    end
    prev_cand = cand;
    for (int i = `VEC_ADC_DELAY - 1; i > 0; i--) begin
      col_hist[i] = col_hist[i-1];
    end
    col_hist[0] = dc;
    last_x = dx;
    last_y = dy;
  endtask

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    timeout_hit = 1'b1;
    // waits for good while the block below ends the run
    @(negedge timeout_hit);
  endtask

  always @(posedge timeout_hit) begin
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // beam off at the last position until model queue and fifo are empty
  // at least one full pipeline flush first
  task automatic drain();
    int   n;
    int   left;
    logic busy;
    busy = 1'b1;
    n = 0;
    while (busy && n < 200) begin
      drive(last_x, last_y, 3'b000);
      left = exp_q.size();
      @(negedge adc_clk);
      busy = point_valid || left != 0 || n < `VEC_COLOR_DELAY + 2;
      n++;
    end
    if (busy) abort_run("FIFO or model queue still busy after 200 cycles");
  endtask

  task automatic random_lit(input int n);
    for (int k = 0; k < n; k++) begin
      drive({$random(seed)} % (1 << `VEC_DATA_WIDTH), {$random(seed)} % (1 << `VEC_DATA_WIDTH),
            3'({$random(seed)} % 7 + 1));
    end
  endtask

  // negative want skips the point count
  task automatic report_test(input string name, input int want);
    int got;
    got = out_cnt - test_out;
    if (want >= 0) begin
      assert (got == want) else begin
        $display("error at %0t: %s gave %0d points, expected %0d", $time, name, got, want);
        err_cnt++;
      end
    end
    if (err_cnt == test_err) pass_cnt++;
    else fail_cnt++;
    $display("test %s done: %0d points, %0d errors", name, got, err_cnt - test_err);
    test_err = err_cnt;
    test_out = out_cnt;
  endtask

  // valid and ready high here means the head word goes on the next edge
  always @(negedge adc_clk) begin : monitor
    vec_pkg::point_t got;
    got = {point_x, point_y, point_red, point_grn, point_blu};
    if (rst_n && point_valid && point_ready) begin
      out_cnt++;
      assert (exp_q.size() != 0) else begin
        $display("error at %0t: point %h not predicted by the model", $time, got);
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        assert (got == exp_q[0]) else begin
          $display("error at %0t: point %h, expected %h", $time, got, exp_q[0]);
          err_cnt++;
        end
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin
    int   n;
    logic ovf_seen;
    seed = 32'hff45;
    adc_clk = 1'b0;
    rst_n = 1'b0;
    adc_x = '0;
    adc_y = '0;
    {red, grn, blu} = 3'b000;
    orient = vec_pkg::ORIENT_MIRROR_X;
    point_ready = 1'b1;
    mode = vec_pkg::ORIENT_MIRROR_X;
    ready_sel = 1'b1;
    prev_cand = '0;
    for (int i = 0; i < `VEC_ADC_DELAY; i++) begin
      col_hist[i] = 3'b000;
    end
    last_x = 0;
    last_y = 0;
    {err_cnt, out_cnt, test_err, test_out, pass_cnt, fail_cnt} = '0;
    timeout_hit = 1'b0;
    repeat (3) @(posedge adc_clk);
    rst_n <= 1'b1;

    // beam off while the position wanders
    for (int k = 0; k < 24; k++) begin
      drive({$random(seed)} % 1024, {$random(seed)} % 1024, 3'b000);
      @(negedge adc_clk);
      assert (!point_valid && !overflow) else begin
        $display("error at %0t: valid or overflow high with the beam off", $time);
        err_cnt++;
      end
    end
    drain();
    report_test("reset_idle", 0);

    random_lit(60);
    drain();
    report_test("scale_mirror_x", -1);

    // pulse at sample 3 pairs with ramp sample 3 + VEC_ADC_DELAY
    for (int k = 0; k < 16; k++) begin
      drive(200 + k, 600 + k, (k == 3) ? 3'b010 : 3'b000);
    end
    drain();
    report_test("colour_align", 1);

    repeat (20) drive(400, 300, 3'b100);
    repeat (10) drive(400, 300, 3'b001);
    drain();
    report_test("dup_suppress", 2);

    for (int m = 1; m < 4; m++) begin
      mode = vec_pkg::orient_t'(m);
      random_lit(30);
    end
    drain();
    report_test("orient_modes", -1);

    // stalled consumer takes 20 distinct lit points
    mode = vec_pkg::ORIENT_MIRROR_X;
    ready_sel = 1'b0;
    for (int k = 0; k < 20 + `VEC_ADC_DELAY; k++) begin
      drive(8 * k, 500, 3'b100);
    end
    n = 0;
    ovf_seen = 1'b0;
    // beam off until overflow shows and the last writes have left the pipeline
    while ((!ovf_seen || n < `VEC_COLOR_DELAY + 2) && n < 50) begin
      drive(last_x, last_y, 3'b000);
      @(negedge adc_clk);
      ovf_seen = ovf_seen || overflow;
      n++;
    end
    if (!ovf_seen) abort_run("overflow never rose with the consumer stalled");
    // only the oldest 16 fit and later writes are lost
    while (exp_q.size() > (1 << `VEC_FIFO_AW)) begin
      void'(exp_q.pop_back());
    end
    ready_sel = 1'b1;
    drain();
    assert (overflow) else begin
      $display("error at %0t: overflow cleared without reset", $time);
      err_cnt++;
    end
    report_test("back_pressure", 1 << `VEC_FIFO_AW);

    $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
